/* all.f */
+incdir+include
design/opl3_reg_pkg.sv
design/opl3_op_pkg.sv
design/ksl_add_rom.sv
design/opl3_axil_regs.sv
design/op_atten_pipe.sv
design/opl3_atten_top.sv
tb/atten_asserts.sv
tb/atten_checker.sv
tb/tb_top.sv

/* design/ksl_add_rom.sv */
// Two-stage key-scale attenuation lookup from fnum, block and ksl.
`default_nettype none
`include "opl3_config.svh"

module ksl_add_rom (
    input  logic                        clk,
    input  logic [`REG_FNUM_WIDTH-1:0]  fnum,
    input  logic [`REG_BLOCK_WIDTH-1:0] block,
    input  logic [`REG_KSL_WIDTH-1:0]   ksl,
    output logic [`KSL_ADD_WIDTH-1:0]   ksl_add
);
    localparam int W = `KSL_ADD_WIDTH;

    logic [W-2:0]               rom_p1;
    logic signed [W-1:0]        blk_off_p1;
    logic [`REG_KSL_WIDTH-1:0]  ksl_p1;
    logic signed [W-1:0]        sum_p1;
    logic [W-1:0]               pos_p1;

    // Stage 1. Table on the top four fnum bits.
    always_ff @(posedge clk) begin
        case (fnum[`REG_FNUM_WIDTH-1 -: 4])
            4'd0:  rom_p1 <= 7'd0;
            4'd1:  rom_p1 <= 7'd32;
            4'd2:  rom_p1 <= 7'd40;
            4'd3:  rom_p1 <= 7'd45;
            4'd4:  rom_p1 <= 7'd48;
            4'd5:  rom_p1 <= 7'd51;
            4'd6:  rom_p1 <= 7'd53;
            4'd7:  rom_p1 <= 7'd55;
            4'd8:  rom_p1 <= 7'd56;
            4'd9:  rom_p1 <= 7'd58;
            4'd10: rom_p1 <= 7'd59;
            4'd11: rom_p1 <= 7'd60;
            4'd12: rom_p1 <= 7'd61;
            4'd13: rom_p1 <= 7'd62;
            4'd14: rom_p1 <= 7'd63;
            default: rom_p1 <= 7'd64;
        endcase
        // Octave offset, always negative.
        blk_off_p1 <= W'(block) - W'(8);
        // Ksl travels with its fnum and block.
        ksl_p1     <= ksl;
    end

    // Eight dB steps per octave below the top.
    assign sum_p1 = $signed({1'b0, rom_p1}) + (blk_off_p1 <<< 3);
    // Clamp at zero.
    assign pos_p1 = (sum_p1 <= 0) ? '0 : W'(sum_p1);

    // Stage 2. Ksl scaling in the chip's order.
    always_ff @(posedge clk) begin
        case (ksl_p1)
            2'd0:    ksl_add <= '0;
            2'd1:    ksl_add <= pos_p1 << 1;
            2'd2:    ksl_add <= pos_p1;
            default: ksl_add <= pos_p1 << 2;
        endcase
    end

endmodule

`default_nettype wire

/* design/op_atten_pipe.sv */
// Slot sequencer and three-stage pipeline summing total level and key-scale attenuation.
`default_nettype none
`include "opl3_config.svh"

module op_atten_pipe (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic [`CH_IDX_WIDTH-1:0] slot_ch,
    input  opl3_reg_pkg::ch_cfg_t    slot_cfg,
    output opl3_op_pkg::op_slot_t    slot_out
);
    import opl3_reg_pkg::*;
    import opl3_op_pkg::*;

    // Fields riding alongside the ROM.
    typedef struct packed {
        logic                     valid;
        logic [`CH_IDX_WIDTH-1:0] channel;
        logic                     key_on;
        logic [`REG_TL_WIDTH-1:0] tl;
    } stage_t;

    logic [`CH_IDX_WIDTH-1:0] ch_q;
    stage_t                   p1_q;
    stage_t                   p2_q;
    logic [`KSL_ADD_WIDTH-1:0] ksl_add;

    // Channel counter, 0 to 8 and wrap.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ch_q <= '0;
        end else if (ch_q == `CH_IDX_WIDTH'(`NUM_CHANNELS - 1)) begin
            ch_q <= '0;
        end else begin
            ch_q <= ch_q + 1'b1;
        end
    end

    assign slot_ch = ch_q;

    // Key-scale lookup, two cycles.
    ksl_add_rom ksl_rom_i (
        .clk     (clk),
        .fnum    (slot_cfg.fnum),
        .block   (slot_cfg.block),
        .ksl     (slot_cfg.ksl),
        .ksl_add (ksl_add)
    );

    // Stages 1 and 2.
    always_ff @(posedge clk) begin
        p1_q.channel <= ch_q;
        p1_q.key_on  <= slot_cfg.key_on;
        p1_q.tl      <= slot_cfg.tl;
        p2_q.channel <= p1_q.channel;
        p2_q.key_on  <= p1_q.key_on;
        p2_q.tl      <= p1_q.tl;
        if (!rst_n) begin
            p1_q.valid <= 1'b0;
            p2_q.valid <= 1'b0;
        end else begin
            p1_q.valid <= 1'b1;
            p2_q.valid <= p1_q.valid;
        end
    end

    // Stage 3. Four times tl plus key scaling, at most 476.
    always_ff @(posedge clk) begin
        slot_out.channel <= p2_q.channel;
        slot_out.key_on  <= p2_q.key_on;
        slot_out.atten   <= (`ATTEN_WIDTH'(p2_q.tl) << 2) + `ATTEN_WIDTH'(ksl_add);
        if (!rst_n) begin
            slot_out.valid <= 1'b0;
        end else begin
            slot_out.valid <= p2_q.valid;
        end
    end

endmodule

`default_nettype wire

/* design/opl3_atten_top.sv */
// Level-scaling top: register file feeding the operator attenuation pipeline.
`default_nettype none
`include "opl3_config.svh"

module opl3_atten_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [7:0]            awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [7:0]            araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    output opl3_op_pkg::op_slot_t slot_out
);
    import opl3_reg_pkg::*;

    // Channel request and its configuration.
    logic [`CH_IDX_WIDTH-1:0] slot_ch;
    ch_cfg_t                  slot_cfg;

    opl3_axil_regs regs_i (
        .clk     (clk),     .rst_n   (rst_n),
        .awaddr  (awaddr),  .awvalid (awvalid), .awready (awready),
        .wdata   (wdata),   .wstrb   (wstrb),   .wvalid  (wvalid),  .wready (wready),
        .bresp   (bresp),   .bvalid  (bvalid),  .bready  (bready),
        .araddr  (araddr),  .arvalid (arvalid), .arready (arready),
        .rdata   (rdata),   .rresp   (rresp),   .rvalid  (rvalid),  .rready (rready),
        .slot_ch (slot_ch), .slot_cfg (slot_cfg)
    );

    op_atten_pipe pipe_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .slot_ch  (slot_ch),
        .slot_cfg (slot_cfg),
        .slot_out (slot_out)
    );

endmodule

`default_nettype wire

/* design/opl3_axil_regs.sv */
// AXI4-Lite slave holding the per-channel registers and serving one channel's configuration.
`default_nettype none
`include "opl3_config.svh"

module opl3_axil_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    // Write address and data.
    input  logic [7:0]               awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    // Write response.
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    // Read address and data.
    input  logic [7:0]               araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [31:0]              rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    // Slot lookup port.
    input  logic [`CH_IDX_WIDTH-1:0] slot_ch,
    output opl3_reg_pkg::ch_cfg_t    slot_cfg
);
    import opl3_reg_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Three bytes per channel indexed by group.
    opl3_reg_word_u regs [`NUM_CHANNELS][`NUM_GROUPS];

    logic [1:0]               wr_grp;
    logic [1:0]               rd_grp;
    logic [`CH_IDX_WIDTH-1:0] wr_ch;
    logic [`CH_IDX_WIDTH-1:0] rd_ch;
    logic                     wr_ok;
    logic                     rd_ok;
    logic                     wr_ready;
    logic                     wr_hs;
    logic                     rd_hs;
    opl3_reg_word_u           wr_word;
    opl3_reg_word_u           lo_w;
    opl3_reg_word_u           blk_w;
    opl3_reg_word_u           lvl_w;

    // Word address bits [7:2] split into group and channel.
    assign wr_grp = awaddr[7:6];
    assign wr_ch  = awaddr[5:2];
    assign rd_grp = araddr[7:6];
    assign rd_ch  = araddr[5:2];

    // Channel 9 and up, or group 3, is an error.
    assign wr_ok = (wr_ch < `NUM_CHANNELS) && (wr_grp != 2'd3);
    assign rd_ok = (rd_ch < `NUM_CHANNELS) && (rd_grp != 2'd3);

    // Address and data accepted together.
    assign awready = wr_ready;
    assign wready  = wr_ready;
    assign wr_hs   = wr_ready && awvalid && wvalid;
    assign rd_hs   = arready && arvalid;

    // Byte lane 0 only.
    assign wr_word = wdata[7:0];

    // Handshake state.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            // One-cycle ready pulse held off while a response waits.
            wr_ready <= !wr_ready && !bvalid && awvalid && wvalid;
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            // Ready again once the pending read data is taken.
            arready <= !rd_hs && (!rvalid || rready);
        end
    end

    // Response payload.
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_hs) begin
            rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            rdata <= rd_ok ? {24'b0, regs[rd_ch][rd_grp]} : 32'b0;
        end
    end

    // Register array, written on the handshake edge.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int c = 0; c < `NUM_CHANNELS; c++) begin
                for (int g = 0; g < `NUM_GROUPS; g++) begin
                    regs[c][g] <= '0;
                end
            end
        end else if (wr_hs && wr_ok && wstrb[0]) begin
            regs[wr_ch][wr_grp] <= wr_word;
        end
    end

    // Configuration of the slot channel, decoded through both views.
    always_comb begin
        lo_w            = regs[slot_ch][`GRP_FNUM_LO];
        blk_w           = regs[slot_ch][`GRP_BLOCK];
        lvl_w           = regs[slot_ch][`GRP_LEVEL];
        slot_cfg.fnum   = {blk_w.blk.fnum_hi, lo_w};
        slot_cfg.block  = blk_w.blk.block;
        slot_cfg.key_on = blk_w.blk.key_on;
        slot_cfg.ksl    = lvl_w.lvl.ksl;
        slot_cfg.tl     = lvl_w.lvl.tl;
    end

endmodule

`default_nettype wire

/* design/opl3_op_pkg.sv */
// Operator-side types: the per-slot attenuation word on the output stream.
`default_nettype none
`include "opl3_config.svh"

package opl3_op_pkg;

    // One time slot leaving the attenuation pipeline.
    // No ready, slots never stall.
    typedef struct packed {
        logic                     valid;
        logic [`CH_IDX_WIDTH-1:0] channel;
        logic                     key_on;
        // Total attenuation, tl plus key scaling.
        logic [`ATTEN_WIDTH-1:0]  atten;
    } op_slot_t;

endpackage

`default_nettype wire

/* design/opl3_reg_pkg.sv */
// Register-side types: register word views and per-channel configuration.
`default_nettype none
`include "opl3_config.svh"

package opl3_reg_pkg;

    // Block register layout, as in the chip's B0 group.
    typedef struct packed {
        logic [1:0]                  pad;
        logic                        key_on;
        logic [`REG_BLOCK_WIDTH-1:0] block;
        logic [`REG_FNUM_WIDTH-9:0]  fnum_hi;
    } blk_view_t;

    // Level register layout, as in the chip's 40 group.
    typedef struct packed {
        logic [`REG_KSL_WIDTH-1:0] ksl;
        logic [`REG_TL_WIDTH-1:0]  tl;
    } lvl_view_t;

    // One host register byte, read through either view.
    typedef union packed {
        blk_view_t blk;
        lvl_view_t lvl;
    } opl3_reg_word_u;

    // Configuration of one channel as seen by the pipeline.
    typedef struct packed {
        logic [`REG_FNUM_WIDTH-1:0]  fnum;
        logic [`REG_BLOCK_WIDTH-1:0] block;
        logic                        key_on;
        logic [`REG_KSL_WIDTH-1:0]   ksl;
        logic [`REG_TL_WIDTH-1:0]    tl;
    } ch_cfg_t;

endpackage

`default_nettype wire

/* include/opl3_config.svh */
// OPL3 level-scaling configuration: channel count, field widths and register groups.
`ifndef OPL3_CONFIG_SVH
`define OPL3_CONFIG_SVH

// Channel count and slot index width.
`define NUM_CHANNELS    9
`define CH_IDX_WIDTH    4

// Register field widths.
`define REG_FNUM_WIDTH  10
`define REG_BLOCK_WIDTH 3
`define REG_KSL_WIDTH   2
`define REG_TL_WIDTH    6

// Attenuation widths.
`define KSL_ADD_WIDTH   8
`define ATTEN_WIDTH     9

// Register groups, address bits [5:4] of the word address.
`define GRP_FNUM_LO     0
`define GRP_BLOCK       1
`define GRP_LEVEL       2
`define NUM_GROUPS      3

`endif

/* tb/atten_asserts.sv */
// Bound checks on AXI response hold and the slot stream.
`default_nettype none
`include "opl3_config.svh"

module atten_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  bvalid,
    input logic                  bready,
    input logic                  rvalid,
    input logic                  rready,
    input opl3_op_pkg::op_slot_t slot_out
);
    timeunit 1ns;
    timeprecision 1ps;

    // Failures so far, read by the testbench top.
    int fail_count = 0;

    // Responses hold until taken.
    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else begin
            fail_count++;
            $error("rvalid dropped before rready");
        end

    // Only real channels leave the pipeline.
    channel_range: assert property (@(posedge clk) disable iff (!rst_n)
        slot_out.valid |-> slot_out.channel < `NUM_CHANNELS)
        else begin
            fail_count++;
            $error("slot channel out of range");
        end

    // Once running, every cycle carries a slot.
    valid_steady: assert property (@(posedge clk) disable iff (!rst_n)
        slot_out.valid |=> slot_out.valid)
        else begin
            fail_count++;
            $error("slot stream lost valid");
        end

endmodule

`default_nettype wire

/* tb/atten_checker.sv */
// Scoreboard with shadow registers, a reference attenuation model and stream and read checks.
`default_nettype none
`include "opl3_config.svh"

module atten_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [7:0]            awaddr,
    input  logic                  awvalid,
    input  logic                  awready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    input  logic                  wready,
    input  logic [1:0]            bresp,
    input  logic                  bvalid,
    input  logic                  bready,
    input  logic [7:0]            araddr,
    input  logic                  arvalid,
    input  logic                  arready,
    input  logic [31:0]           rdata,
    input  logic [1:0]            rresp,
    input  logic                  rvalid,
    input  logic                  rready,
    input  opl3_op_pkg::op_slot_t slot_out,
    output int                    mismatches,
    output int                    slots_checked,
    output int                    reads_checked
);
    timeunit 1ns;
    timeprecision 1ps;

    import opl3_op_pkg::*;

    // Key-scale base per top four fnum bits.
    localparam int KSL_TABLE [16] = '{0, 32, 40, 45, 48, 51, 53, 55,
                                      56, 58, 59, 60, 61, 62, 63, 64};

    logic [7:0]  shadow [`NUM_CHANNELS][`NUM_GROUPS];
    // Expected slots, newest first.
    op_slot_t    hist [3];
    int          issue_ch;
    logic [1:0]  exp_bresp;
    logic [1:0]  exp_rresp;
    logic [31:0] exp_rdata;

    function automatic bit addr_is_valid(input logic [7:0] addr);
        return (addr[5:2] < `NUM_CHANNELS) && (addr[7:6] != 2'd3);
    endfunction

    // 8 steps per octave below block 8, clamped at zero, then ksl scaling.
    function automatic int key_scale(input logic [9:0] fnum, input logic [2:0] block,
                                     input logic [1:0] ksl);
        int base;
        base = KSL_TABLE[fnum[9:6]] + 8 * (int'(block) - 8);
        if (base <= 0 || ksl == 2'd0) begin
            return 0;
        end
        case (ksl)
            2'd1:    return base * 2;
            2'd2:    return base;
            default: return base * 4;
        endcase
    endfunction

    function automatic op_slot_t expected_slot(input int ch);
        op_slot_t   s;
        logic [7:0] lo;
        logic [7:0] blk;
        logic [7:0] lvl;
        lo        = shadow[ch][`GRP_FNUM_LO];
        blk       = shadow[ch][`GRP_BLOCK];
        lvl       = shadow[ch][`GRP_LEVEL];
        s.valid   = 1'b1;
        s.channel = ch[3:0];
        s.key_on  = blk[5];
        s.atten   = 9'(4 * lvl[5:0] + key_scale({blk[1:0], lo}, blk[4:2], lvl[7:6]));
        return s;
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        mismatches++;
        $display("mismatch %s: got 0x%h expected 0x%h at %0d ns", name, got, want, $time);
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            mismatches    = 0;
            slots_checked = 0;
            reads_checked = 0;
            issue_ch      = 0;
            for (int i = 0; i < 3; i++) begin
                hist[i] = '0;
            end
            for (int c = 0; c < `NUM_CHANNELS; c++) begin
                for (int g = 0; g < `NUM_GROUPS; g++) begin
                    shadow[c][g] = '0;
                end
            end
        end else begin
            // Slot issued three edges back.
            if (slot_out.valid !== hist[2].valid) begin
                flag_mismatch("slot_out.valid", 32'(slot_out.valid), 32'(hist[2].valid));
            end else if (hist[2].valid) begin
                slots_checked++;
                if (slot_out.channel !== hist[2].channel) begin
                    flag_mismatch("slot_out.channel", 32'(slot_out.channel),
                                  32'(hist[2].channel));
                end
                if (slot_out.key_on !== hist[2].key_on) begin
                    flag_mismatch("slot_out.key_on", 32'(slot_out.key_on),
                                  32'(hist[2].key_on));
                end
                if (slot_out.atten !== hist[2].atten) begin
                    flag_mismatch("slot_out.atten", 32'(slot_out.atten), 32'(hist[2].atten));
                end
            end
            // Config seen before this edge's write lands.
            hist[2]  = hist[1];
            hist[1]  = hist[0];
            hist[0]  = expected_slot(issue_ch);
            issue_ch = (issue_ch + 1) % `NUM_CHANNELS;

            // Responses first, then new requests.
            if (bvalid && bready && bresp !== exp_bresp) begin
                flag_mismatch("bresp", 32'(bresp), 32'(exp_bresp));
            end
            if (rvalid && rready) begin
                reads_checked++;
                if (rresp !== exp_rresp) begin
                    flag_mismatch("rresp", 32'(rresp), 32'(exp_rresp));
                end
                if (rdata !== exp_rdata) begin
                    flag_mismatch("rdata", rdata, exp_rdata);
                end
            end
            if (awvalid && awready && wvalid && wready) begin
                exp_bresp = addr_is_valid(awaddr) ? 2'b00 : 2'b10;
                if (addr_is_valid(awaddr) && wstrb[0]) begin
                    shadow[awaddr[5:2]][awaddr[7:6]] = wdata[7:0];
                end
            end
            if (arvalid && arready) begin
                if (addr_is_valid(araddr)) begin
                    exp_rresp = 2'b00;
                    exp_rdata = {24'b0, shadow[araddr[5:2]][araddr[7:6]]};
                end else begin
                    exp_rresp = 2'b10;
                    exp_rdata = '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_top.sv */
// Testbench top: clock, reset, random AXI4-Lite register traffic and the final verdict.
`default_nettype none
`include "opl3_config.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    import opl3_op_pkg::*;

    localparam int NUM_WRITES = 300;
    localparam int WAIT_LIMIT = 50;

    logic        clk;
    logic        rst_n;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    op_slot_t    slot_out;

    // Counts from the checker.
    int mismatches;
    int slots_checked;
    int reads_checked;

    int          other_errors;
    logic [31:0] lcg_state;

    opl3_atten_top dut_i (.*);

    atten_checker checker_i (.*);

    bind opl3_atten_top atten_asserts asserts_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .bvalid   (bvalid),
        .bready   (bready),
        .rvalid   (rvalid),
        .rready   (rready),
        .slot_out (slot_out)
    );

    // 20 ns clock.
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // LCG, upper half of the state.
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    // Word address is {group, channel}.
    function automatic logic [7:0] reg_addr(input logic [1:0] grp, input logic [3:0] ch);
        return {grp, ch, 2'b00};
    endfunction

    function automatic logic [7:0] pick_addr();
        logic [15:0] r;
        r = next_rand();
        // One in eight goes to the error space.
        if (r[15:13] != 3'd0) begin
            return reg_addr(2'(r[6:5] % 3), 4'(r[12:7] % `NUM_CHANNELS));
        end else if (r[0]) begin
            return reg_addr(2'd3, r[4:1]);
        end else begin
            return reg_addr(2'(r[6:5] % 3), 4'(`NUM_CHANNELS + r[3:1] % 7));
        end
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Polls at falling edges, so the next rising edge completes the handshake.
    task automatic await_flag(input int sel, input string what);
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
            case (sel)
                0:       seen = awready && wready;
                1:       seen = bvalid;
                2:       seen = arready;
                default: seen = rvalid;
            endcase
        end
        if (!seen) begin
            other_errors++;
            $display("timeout: %s did not rise within %0d cycles", what, WAIT_LIMIT);
        end
    endtask

    // Starts and ends 1 ns after a rising edge.
    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        logic [15:0] upper;
        int          hold;
        upper   = next_rand();
        hold    = next_rand() % 3;
        awaddr  = addr;
        wdata   = {upper[7:0], upper, data};
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        await_flag(0, "awready and wready");
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // Random back-pressure on the response.
        idle_cycles(hold);
        bready = 1'b1;
        await_flag(1, "bvalid");
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr);
        int hold;
        hold    = next_rand() % 3;
        araddr  = addr;
        arvalid = 1'b1;
        await_flag(2, "arready");
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        idle_cycles(hold);
        rready = 1'b1;
        await_flag(3, "rvalid");
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    initial begin
        logic [7:0] addr;
        logic [7:0] data;
        lcg_state    = 32'd42;
        other_errors = 0;
        rst_n        = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Channel 0, block 0 with low fnum.
        write_reg(reg_addr(`GRP_FNUM_LO, 4'd0), 8'h10);
        write_reg(reg_addr(`GRP_BLOCK, 4'd0), 8'h20);
        write_reg(reg_addr(`GRP_LEVEL, 4'd0), 8'hc5);
        // Channels 1 and 2, block 7 and fnum 1023, with ksl 0 and ksl 3.
        write_reg(reg_addr(`GRP_FNUM_LO, 4'd1), 8'hff);
        write_reg(reg_addr(`GRP_BLOCK, 4'd1), 8'h3f);
        write_reg(reg_addr(`GRP_LEVEL, 4'd1), 8'h09);
        write_reg(reg_addr(`GRP_FNUM_LO, 4'd2), 8'hff);
        write_reg(reg_addr(`GRP_BLOCK, 4'd2), 8'h3f);
        write_reg(reg_addr(`GRP_LEVEL, 4'd2), 8'hd1);
        idle_cycles(2 * `NUM_CHANNELS);

        for (int i = 0; i < NUM_WRITES; i++) begin
            addr = pick_addr();
            data = 8'(next_rand());
            write_reg(addr, data);
            if (next_rand() % 4 == 0) begin
                read_reg(pick_addr());
            end
        end

        // Read back every valid register.
        for (int g = 0; g < `NUM_GROUPS; g++) begin
            for (int c = 0; c < `NUM_CHANNELS; c++) begin
                read_reg(reg_addr(2'(g), 4'(c)));
            end
        end
        idle_cycles(2 * `NUM_CHANNELS);

        other_errors += dut_i.asserts_i.fail_count;
        if (slots_checked == 0 || reads_checked == 0) begin
            other_errors++;
            $display("no output slots or no read responses were checked");
        end
        $display("checked %0d slots and %0d reads, %0d mismatches, %0d other errors",
                 slots_checked, reads_checked, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
